/* hw/rv32_defines.svh */
`ifndef RV32_DEFINES_SVH
`define RV32_DEFINES_SVH

`define RV32_XLEN      32
`define RV32_RESET_PC  32'h0000_0000

// major opcodes
`define RV32_OP_LUI    7'b0110111
`define RV32_OP_AUIPC  7'b0010111
`define RV32_OP_JAL    7'b1101111
`define RV32_OP_JALR   7'b1100111
`define RV32_OP_BRANCH 7'b1100011
`define RV32_OP_LOAD   7'b0000011
`define RV32_OP_STORE  7'b0100011
`define RV32_OP_IMM    7'b0010011
`define RV32_OP_REG    7'b0110011

// branch conditions
`define RV32_F3_BEQ    3'b000
`define RV32_F3_BNE    3'b001
`define RV32_F3_BLT    3'b100
`define RV32_F3_BGE    3'b101
`define RV32_F3_BLTU   3'b110
`define RV32_F3_BGEU   3'b111

// load and store widths
`define RV32_F3_LB     3'b000
`define RV32_F3_LH     3'b001
`define RV32_F3_LW     3'b010
`define RV32_F3_LBU    3'b100
`define RV32_F3_LHU    3'b101
`define RV32_F3_SB     3'b000
`define RV32_F3_SH     3'b001
`define RV32_F3_SW     3'b010

// alu operations
`define RV32_F3_ADDSUB 3'b000
`define RV32_F3_SLL    3'b001
`define RV32_F3_SLT    3'b010
`define RV32_F3_SLTU   3'b011
`define RV32_F3_XOR    3'b100
`define RV32_F3_SR     3'b101
`define RV32_F3_OR     3'b110
`define RV32_F3_AND    3'b111

// SUB and SRA/SRAI
`define RV32_F7_ALT    7'b0100000

`endif

/* hw/rv32_pkg.sv */
package rv32_pkg;

   // one fetched word, viewed through each base format
   typedef union packed {
      struct packed {
         logic [6:0] funct7;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] rd;
         logic [6:0] opcode;
      } r_fmt;
      struct packed {
         logic [11:0] imm_11_0;
         logic [4:0]  rs1;
         logic [2:0]  funct3;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } i_fmt;
      struct packed {
         logic [6:0] imm_11_5;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] imm_4_0;
         logic [6:0] opcode;
      } s_fmt;
      // branch offset bits are scattered, bit 0 is implied
      struct packed {
         logic       imm_12;
         logic [5:0] imm_10_5;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [3:0] imm_4_1;
         logic       imm_11;
         logic [6:0] opcode;
      } b_fmt;
      struct packed {
         logic [19:0] imm_31_12;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } u_fmt;
      struct packed {
         logic       imm_20;
         logic [9:0] imm_10_1;
         logic       imm_11;
         logic [7:0] imm_19_12;
         logic [4:0] rd;
         logic [6:0] opcode;
      } j_fmt;
   } rv32_instr_u;

endpackage

/* hw/rv32_dec_if.sv */
`timescale 1ns/10ps
`include "rv32_defines.svh"

interface rv32_dec_if;

   logic [4:0]            rd_num;
   logic [4:0]            rs1_num;
   logic [4:0]            rs2_num;
   logic [`RV32_XLEN-1:0] imm;
   // {alt, funct3}; branches put their condition in the low bits
   logic [3:0]            alu_op;
   logic                  alu_use_imm;
   logic                  is_lui;
   logic                  is_auipc;
   logic                  is_jal;
   logic                  is_jalr;
   logic                  is_branch;
   logic                  is_load;
   logic                  is_store;
   logic [2:0]            mem_funct3;
   logic                  writes_rd;

   modport dec (
      output rd_num, rs1_num, rs2_num, imm, alu_op, alu_use_imm,
             is_lui, is_auipc, is_jal, is_jalr, is_branch,
             is_load, is_store, mem_funct3, writes_rd
   );

   modport user (
      input  rd_num, rs1_num, rs2_num, imm, alu_op, alu_use_imm,
             is_lui, is_auipc, is_jal, is_jalr, is_branch,
             is_load, is_store, mem_funct3, writes_rd
   );

endinterface

/* hw/rv32_decoder.sv */
`timescale 1ns/10ps
`include "rv32_defines.svh"

module rv32_decoder import rv32_pkg::*; (
   input  logic                  CLK,
   input  logic                  RST_N,
   input  logic                  capture,
   input  logic [`RV32_XLEN-1:0] instr_word,
   rv32_dec_if.dec               dec
);

   rv32_instr_u instr;

   // cleared to an unmatched opcode, so reset decodes as a no-op
   always_ff @(posedge CLK) begin
      if (!RST_N) begin
         instr <= '0;
      end else if (capture) begin
         instr <= instr_word;
      end
   end

   assign dec.rd_num     = instr.r_fmt.rd;
   assign dec.rs1_num    = instr.r_fmt.rs1;
   assign dec.rs2_num    = instr.r_fmt.rs2;
   assign dec.mem_funct3 = instr.r_fmt.funct3;

   always_comb begin
      dec.imm         = '0;
      dec.alu_op      = 4'b0000;
      dec.alu_use_imm = 1'b0;
      dec.is_lui      = 1'b0;
      dec.is_auipc    = 1'b0;
      dec.is_jal      = 1'b0;
      dec.is_jalr     = 1'b0;
      dec.is_branch   = 1'b0;
      dec.is_load     = 1'b0;
      dec.is_store    = 1'b0;
      dec.writes_rd   = 1'b0;
      case (instr.r_fmt.opcode)
         `RV32_OP_LUI, `RV32_OP_AUIPC: begin
            dec.imm       = {instr.u_fmt.imm_31_12, 12'b0};
            dec.is_lui    = (instr.u_fmt.opcode == `RV32_OP_LUI);
            dec.is_auipc  = (instr.u_fmt.opcode == `RV32_OP_AUIPC);
            dec.writes_rd = 1'b1;
         end
         `RV32_OP_JAL: begin
            dec.imm       = {{11{instr.j_fmt.imm_20}}, instr.j_fmt.imm_20,
                             instr.j_fmt.imm_19_12, instr.j_fmt.imm_11,
                             instr.j_fmt.imm_10_1, 1'b0};
            dec.is_jal    = 1'b1;
            dec.writes_rd = 1'b1;
         end
         `RV32_OP_JALR: begin
            dec.imm         = {{20{instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
            dec.alu_use_imm = 1'b1;
            dec.is_jalr     = 1'b1;
            dec.writes_rd   = 1'b1;
         end
         `RV32_OP_BRANCH: begin
            dec.imm       = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12,
                             instr.b_fmt.imm_11, instr.b_fmt.imm_10_5,
                             instr.b_fmt.imm_4_1, 1'b0};
            dec.alu_op    = {1'b0, instr.b_fmt.funct3};
            dec.is_branch = 1'b1;
         end
         `RV32_OP_LOAD: begin
            dec.imm         = {{20{instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
            dec.alu_use_imm = 1'b1;
            dec.is_load     = 1'b1;
            dec.writes_rd   = 1'b1;
         end
         `RV32_OP_STORE: begin
            dec.imm         = {{20{instr.s_fmt.imm_11_5[6]}}, instr.s_fmt.imm_11_5,
                               instr.s_fmt.imm_4_0};
            dec.alu_use_imm = 1'b1;
            dec.is_store    = 1'b1;
         end
         `RV32_OP_IMM: begin
            dec.imm         = {{20{instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
            // only the shift right immediate has an alternate form
            dec.alu_op      = {(instr.i_fmt.funct3 == `RV32_F3_SR) &&
                               (instr.r_fmt.funct7 == `RV32_F7_ALT), instr.i_fmt.funct3};
            dec.alu_use_imm = 1'b1;
            dec.writes_rd   = 1'b1;
         end
         `RV32_OP_REG: begin
            dec.alu_op    = {instr.r_fmt.funct7 == `RV32_F7_ALT, instr.r_fmt.funct3};
            dec.writes_rd = 1'b1;
         end
         default: begin
            // FENCE and unknown words fall through as no-ops
            dec.writes_rd = 1'b0;
         end
      endcase
   end

endmodule

/* hw/rv32_regfile.sv */
`timescale 1ns/10ps
`include "rv32_defines.svh"

module rv32_regfile (
   input  logic                  CLK,
   input  logic                  RST_N,
   input  logic [4:0]            rs1_num,
   input  logic [4:0]            rs2_num,
   output logic [`RV32_XLEN-1:0] rs1_data,
   output logic [`RV32_XLEN-1:0] rs2_data,
   input  logic                  we,
   input  logic [4:0]            rd_num,
   input  logic [`RV32_XLEN-1:0] rd_data
);

   // x0 has no storage
   logic [`RV32_XLEN-1:0] regs [1:31];

   always_ff @(posedge CLK) begin
      if (!RST_N) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (we && (rd_num != 5'd0)) begin
         regs[rd_num] <= rd_data;
      end
   end

   assign rs1_data = (rs1_num == 5'd0) ? '0 : regs[rs1_num];
   assign rs2_data = (rs2_num == 5'd0) ? '0 : regs[rs2_num];

endmodule

/* hw/rv32_execute.sv */
`timescale 1ns/10ps
`include "rv32_defines.svh"

module rv32_execute (
   input  logic                  CLK,
   input  logic                  RST_N,
   input  logic                  advance,
   input  logic [`RV32_XLEN-1:0] pc,
   input  logic [`RV32_XLEN-1:0] rs1_data,
   input  logic [`RV32_XLEN-1:0] rs2_data,
   rv32_dec_if.user              dec,
   rv32_dec_if.dec               mem_fields,
   output logic [`RV32_XLEN-1:0] alu_result,
   output logic [`RV32_XLEN-1:0] store_data,
   output logic [`RV32_XLEN-1:0] next_pc,
   output logic [`RV32_XLEN-1:0] link_value
);

   logic [`RV32_XLEN-1:0]        op_b;
   logic [4:0]                   shamt;
   logic [`RV32_XLEN-1:0]        alu_out;
   logic signed [`RV32_XLEN-1:0] sra_val;
   logic [`RV32_XLEN-1:0]        result;
   logic [`RV32_XLEN-1:0]        pc_target;
   logic [`RV32_XLEN-1:0]        jalr_sum;
   logic [`RV32_XLEN-1:0]        pc_plus4;
   logic [`RV32_XLEN-1:0]        npc;
   logic                         taken;

   assign op_b    = dec.alu_use_imm ? dec.imm : rs2_data;
   assign shamt   = op_b[4:0];
   // kept apart so the shift stays signed
   assign sra_val = $signed(rs1_data) >>> shamt;

   always_comb begin
      case (dec.alu_op[2:0])
         `RV32_F3_ADDSUB: alu_out = dec.alu_op[3] ? rs1_data - op_b : rs1_data + op_b;
         `RV32_F3_SLL:    alu_out = rs1_data << shamt;
         `RV32_F3_SLT:    alu_out = {31'b0, $signed(rs1_data) < $signed(op_b)};
         `RV32_F3_SLTU:   alu_out = {31'b0, rs1_data < op_b};
         `RV32_F3_XOR:    alu_out = rs1_data ^ op_b;
         `RV32_F3_SR:     alu_out = dec.alu_op[3] ? sra_val : rs1_data >> shamt;
         `RV32_F3_OR:     alu_out = rs1_data | op_b;
         default:         alu_out = rs1_data & op_b;
      endcase
   end

   // branch condition rides in the low alu_op bits
   always_comb begin
      case (dec.alu_op[2:0])
         `RV32_F3_BEQ:  taken = (rs1_data == rs2_data);
         `RV32_F3_BNE:  taken = (rs1_data != rs2_data);
         `RV32_F3_BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
         `RV32_F3_BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
         `RV32_F3_BLTU: taken = (rs1_data < rs2_data);
         `RV32_F3_BGEU: taken = (rs1_data >= rs2_data);
         default:       taken = 1'b0;
      endcase
   end

   assign pc_target = pc + dec.imm;
   assign jalr_sum  = rs1_data + dec.imm;
   assign pc_plus4  = pc + 32'd4;

   assign result = dec.is_lui   ? dec.imm :
                   dec.is_auipc ? pc_target :
                   alu_out;

   assign npc = (dec.is_jal || (dec.is_branch && taken)) ? pc_target :
                dec.is_jalr ? {jalr_sum[`RV32_XLEN-1:1], 1'b0} :
                pc_plus4;

   // results and field copy for memory and writeback
   always_ff @(posedge CLK) begin
      if (advance) begin
         alu_result             <= result;
         store_data             <= rs2_data;
         next_pc                <= npc;
         link_value             <= pc_plus4;
         mem_fields.rd_num      <= dec.rd_num;
         mem_fields.rs1_num     <= dec.rs1_num;
         mem_fields.rs2_num     <= dec.rs2_num;
         mem_fields.imm         <= dec.imm;
         mem_fields.alu_op      <= dec.alu_op;
         mem_fields.alu_use_imm <= dec.alu_use_imm;
         mem_fields.mem_funct3  <= dec.mem_funct3;
      end
   end

   always_ff @(posedge CLK) begin
      if (!RST_N) begin
         mem_fields.is_lui    <= 1'b0;
         mem_fields.is_auipc  <= 1'b0;
         mem_fields.is_jal    <= 1'b0;
         mem_fields.is_jalr   <= 1'b0;
         mem_fields.is_branch <= 1'b0;
         mem_fields.is_load   <= 1'b0;
         mem_fields.is_store  <= 1'b0;
         mem_fields.writes_rd <= 1'b0;
      end else if (advance) begin
         mem_fields.is_lui    <= dec.is_lui;
         mem_fields.is_auipc  <= dec.is_auipc;
         mem_fields.is_jal    <= dec.is_jal;
         mem_fields.is_jalr   <= dec.is_jalr;
         mem_fields.is_branch <= dec.is_branch;
         mem_fields.is_load   <= dec.is_load;
         mem_fields.is_store  <= dec.is_store;
         mem_fields.writes_rd <= dec.writes_rd;
      end
   end

endmodule

/* hw/rv32_lsu.sv */
`timescale 1ns/10ps
`include "rv32_defines.svh"

module rv32_lsu (
   input  logic                  in_memory,
   rv32_dec_if.user              fields,
   input  logic [`RV32_XLEN-1:0] alu_result,
   input  logic [`RV32_XLEN-1:0] store_data,
   input  logic [`RV32_XLEN-1:0] link_value,
   input  logic [`RV32_XLEN-1:0] load_data,
   output logic                  mem_ena,
   output logic [3:0]            mem_wstb,
   output logic [`RV32_XLEN-1:0] mem_addr,
   output logic [`RV32_XLEN-1:0] mem_wdata,
   output logic [`RV32_XLEN-1:0] rd_data
);

   logic [1:0]            lane;
   logic [3:0]            strobe;
   logic [`RV32_XLEN-1:0] shifted;
   logic [`RV32_XLEN-1:0] load_val;

   assign lane     = alu_result[1:0];
   assign mem_addr = alu_result;
   assign mem_ena  = in_memory & (fields.is_load | fields.is_store);
   assign mem_wstb = (in_memory & fields.is_store) ? strobe : 4'b0000;

   // store data copied to every lane, strobes pick the lanes
   always_comb begin
      case (fields.mem_funct3)
         `RV32_F3_SB: begin
            mem_wdata = {4{store_data[7:0]}};
            strobe    = 4'b0001 << lane;
         end
         `RV32_F3_SH: begin
            mem_wdata = {2{store_data[15:0]}};
            strobe    = lane[1] ? 4'b1100 : 4'b0011;
         end
         `RV32_F3_SW: begin
            mem_wdata = store_data;
            strobe    = 4'b1111;
         end
         default: begin
            mem_wdata = store_data;
            strobe    = 4'b0000;
         end
      endcase
   end

   // addressed byte or halfword moved down to bit 0
   assign shifted = load_data >> {lane, 3'b000};

   always_comb begin
      case (fields.mem_funct3)
         `RV32_F3_LB:  load_val = {{24{shifted[7]}}, shifted[7:0]};
         `RV32_F3_LBU: load_val = {24'b0, shifted[7:0]};
         `RV32_F3_LH:  load_val = {{16{shifted[15]}}, shifted[15:0]};
         `RV32_F3_LHU: load_val = {16'b0, shifted[15:0]};
         default:      load_val = load_data;
      endcase
   end

   assign rd_data = fields.is_load                    ? load_val :
                    (fields.is_jal | fields.is_jalr) ? link_value :
                    alu_result;

endmodule

/* hw/rv32_core.sv */
`timescale 1ns/10ps
`include "rv32_defines.svh"

module rv32_core (
   input  logic                  CLK,
   input  logic                  RST_N,
   input  logic                  I_MEM_WAIT,
   output logic                  I_MEM_ENA,
   output logic [`RV32_XLEN-1:0] I_MEM_ADDR,
   input  logic [`RV32_XLEN-1:0] I_MEM_RDATA,
   input  logic                  D_MEM_WAIT,
   output logic                  D_MEM_ENA,
   output logic [3:0]            D_MEM_WSTB,
   output logic [`RV32_XLEN-1:0] D_MEM_ADDR,
   output logic [`RV32_XLEN-1:0] D_MEM_WDATA,
   input  logic [`RV32_XLEN-1:0] D_MEM_RDATA
);

   localparam logic [2:0] S_IDLE      = 3'd0;
   localparam logic [2:0] S_FETCH     = 3'd1;
   localparam logic [2:0] S_DECODE    = 3'd2;
   localparam logic [2:0] S_EXECUTE   = 3'd3;
   localparam logic [2:0] S_MEMORY    = 3'd4;
   localparam logic [2:0] S_WRITEBACK = 3'd5;

   logic [2:0]            state;
   logic [`RV32_XLEN-1:0] pc;
   logic [`RV32_XLEN-1:0] rs1_data;
   logic [`RV32_XLEN-1:0] rs2_data;
   logic [`RV32_XLEN-1:0] alu_result;
   logic [`RV32_XLEN-1:0] store_data;
   logic [`RV32_XLEN-1:0] next_pc;
   logic [`RV32_XLEN-1:0] link_value;
   logic [`RV32_XLEN-1:0] rd_data;
   logic                  rf_we;

   rv32_dec_if dec_fields ();
   rv32_dec_if mem_fields ();

   always_ff @(posedge CLK) begin
      if (!RST_N) begin
         state <= S_IDLE;
      end else begin
         case (state)
            S_IDLE, S_WRITEBACK: begin
               if (!I_MEM_WAIT) begin
                  state <= S_FETCH;
               end
            end
            S_FETCH:   state <= S_DECODE;
            S_DECODE:  state <= S_EXECUTE;
            S_EXECUTE: state <= S_MEMORY;
            S_MEMORY: begin
               if (!D_MEM_WAIT) begin
                  state <= S_WRITEBACK;
               end
            end
            default:   state <= S_IDLE;
         endcase
      end
   end

   // pc moves on leaving memory, ahead of the next fetch
   always_ff @(posedge CLK) begin
      if (!RST_N) begin
         pc <= `RV32_RESET_PC;
      end else if ((state == S_MEMORY) && !D_MEM_WAIT) begin
         pc <= next_pc;
      end
   end

   assign I_MEM_ENA  = (state == S_IDLE) || (state == S_WRITEBACK);
   assign I_MEM_ADDR = pc;
   assign rf_we      = (state == S_WRITEBACK) && mem_fields.writes_rd;

   rv32_decoder u_decoder (
      .CLK        (CLK),
      .RST_N      (RST_N),
      .capture    (state == S_FETCH),
      .instr_word (I_MEM_RDATA),
      .dec        (dec_fields.dec)
   );

   rv32_regfile u_regfile (
      .CLK      (CLK),
      .RST_N    (RST_N),
      .rs1_num  (dec_fields.rs1_num),
      .rs2_num  (dec_fields.rs2_num),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data),
      .we       (rf_we),
      .rd_num   (mem_fields.rd_num),
      .rd_data  (rd_data)
   );

   rv32_execute u_execute (
      .CLK        (CLK),
      .RST_N      (RST_N),
      .advance    (state == S_DECODE),
      .pc         (pc),
      .rs1_data   (rs1_data),
      .rs2_data   (rs2_data),
      .dec        (dec_fields.user),
      .mem_fields (mem_fields.dec),
      .alu_result (alu_result),
      .store_data (store_data),
      .next_pc    (next_pc),
      .link_value (link_value)
   );

   rv32_lsu u_lsu (
      .in_memory  (state == S_MEMORY),
      .fields     (mem_fields.user),
      .alu_result (alu_result),
      .store_data (store_data),
      .link_value (link_value),
      .load_data  (D_MEM_RDATA),
      .mem_ena    (D_MEM_ENA),
      .mem_wstb   (D_MEM_WSTB),
      .mem_addr   (D_MEM_ADDR),
      .mem_wdata  (D_MEM_WDATA),
      .rd_data    (rd_data)
   );

endmodule

/* verification/rv32_tb_mem.sv */
`timescale 1ns/10ps

module rv32_tb_mem (
   input  logic        CLK,
   input  logic        i_mem_ena,
   input  logic        i_mem_wait,
   input  logic [31:0] i_mem_addr,
   output logic [31:0] i_mem_rdata,
   input  logic        d_mem_ena,
   input  logic        d_mem_wait,
   input  logic [3:0]  d_mem_wstb,
   input  logic [31:0] d_mem_addr,
   input  logic [31:0] d_mem_wdata,
   output logic [31:0] d_mem_rdata
);

   // program words, written by the testbench before reset ends
   logic [31:0] rom [0:255];
   logic [31:0] ram [0:1023];

   // every word differs, built from its full index
   function automatic logic [31:0] fill_word(input int idx);
      logic [31:0] w;
      w = idx;
      return (w * 32'h0100_0193) ^ 32'h8B3C_D24F;
   endfunction

   initial begin
      i_mem_rdata = '0;
      d_mem_rdata = '0;
      for (int i = 0; i < 1024; i++) begin
         ram[i] = fill_word(i);
      end
   end

   // read data shows up the cycle after acceptance and then holds
   always @(posedge CLK) begin
      if (i_mem_ena && !i_mem_wait) begin
         i_mem_rdata <= rom[i_mem_addr[9:2]];
      end
   end

   always @(posedge CLK) begin
      if (d_mem_ena && !d_mem_wait) begin
         d_mem_rdata <= ram[d_mem_addr[11:2]];
         for (int b = 0; b < 4; b++) begin
            if (d_mem_wstb[b]) begin
               ram[d_mem_addr[11:2]][8*b +: 8] <= d_mem_wdata[8*b +: 8];
            end
         end
      end
   end

endmodule

/* verification/rv32_tb.sv */
`timescale 1ns/10ps
`include "rv32_defines.svh"

module rv32_tb import rv32_pkg::*; ();

   logic        CLK;
   logic        RST_N;
   logic        I_MEM_WAIT;
   logic        D_MEM_WAIT;
   logic        I_MEM_ENA;
   logic        D_MEM_ENA;
   logic [3:0]  D_MEM_WSTB;
   logic [31:0] I_MEM_ADDR;
   logic [31:0] I_MEM_RDATA;
   logic [31:0] D_MEM_ADDR;
   logic [31:0] D_MEM_WDATA;
   logic [31:0] D_MEM_RDATA;

   integer      seed = 32'h59b1f6f2;
   logic        random_waits;
   int          value_errs;
   int          other_errs;
   logic [31:0] pc_build;
   logic [31:0] exp_next [0:255];
   logic [31:0] exp_addr [$];
   logic [31:0] exp_data [$];
   logic [3:0]  exp_strb [$];
   int          store_count;
   int          cycle;
   int          last_fetch_cycle;
   logic [31:0] prev_fetch;
   logic        first_fetch;
   logic        halted;
   logic        rst_held;

   rv32_core u_dut (
      .CLK(CLK), .RST_N(RST_N),
      .I_MEM_WAIT(I_MEM_WAIT), .I_MEM_ENA(I_MEM_ENA),
      .I_MEM_ADDR(I_MEM_ADDR), .I_MEM_RDATA(I_MEM_RDATA),
      .D_MEM_WAIT(D_MEM_WAIT), .D_MEM_ENA(D_MEM_ENA), .D_MEM_WSTB(D_MEM_WSTB),
      .D_MEM_ADDR(D_MEM_ADDR), .D_MEM_WDATA(D_MEM_WDATA), .D_MEM_RDATA(D_MEM_RDATA)
   );

   rv32_tb_mem u_mem (
      .CLK(CLK),
      .i_mem_ena(I_MEM_ENA), .i_mem_wait(I_MEM_WAIT),
      .i_mem_addr(I_MEM_ADDR), .i_mem_rdata(I_MEM_RDATA),
      .d_mem_ena(D_MEM_ENA), .d_mem_wait(D_MEM_WAIT), .d_mem_wstb(D_MEM_WSTB),
      .d_mem_addr(D_MEM_ADDR), .d_mem_wdata(D_MEM_WDATA), .d_mem_rdata(D_MEM_RDATA)
   );

   always #5 CLK = ~CLK;

   // instruction encoders
   function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
      rv32_instr_u u;
      u.r_fmt = '{f7, rs2, rs1, f3, rd, `RV32_OP_REG};
      return u;
   endfunction

   function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
      rv32_instr_u u;
      u.i_fmt = '{imm, rs1, f3, rd, op};
      return u;
   endfunction

   function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
      rv32_instr_u u;
      u.s_fmt = '{imm[11:5], rs2, rs1, f3, imm[4:0], `RV32_OP_STORE};
      return u;
   endfunction

   function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
      rv32_instr_u u;
      u.b_fmt = '{off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV32_OP_BRANCH};
      return u;
   endfunction

   function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] op);
      rv32_instr_u u;
      u.u_fmt = '{imm, rd, op};
      return u;
   endfunction

   function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
      rv32_instr_u u;
      u.j_fmt = '{off[20], off[10:1], off[11], off[19:12], rd, `RV32_OP_JAL};
      return u;
   endfunction

   task automatic place_jump(input logic [31:0] w, input logic [31:0] target);
      u_mem.rom[pc_build[9:2]] = w;
      exp_next[pc_build[9:2]] = target;
      pc_build = pc_build + 4;
   endtask

   task automatic place(input logic [31:0] w);
      place_jump(w, pc_build + 4);
   endtask

   task automatic expect_store(input logic [31:0] a, input logic [31:0] d,
                               input logic [3:0] s);
      exp_addr.push_back(a);
      exp_data.push_back(d);
      exp_strb.push_back(s);
   endtask

   // store of x4 to base+off, value known to the testbench
   task automatic store_x4(input logic [11:0] off, input logic [31:0] value);
      place(s_type(off, 5'd4, 5'd10, `RV32_F3_SW));
      expect_store(32'h100 + off, value, 4'b1111);
   endtask

   // a store nobody expects, placed where execution must not go
   task automatic place_trap_store();
      place(s_type(12'h1F0, 5'd0, 5'd0, `RV32_F3_SW));
   endtask

   task automatic cond_branch(input logic [2:0] f3, input logic [4:0] ra,
                              input logic [4:0] rb, input logic taken, input logic [11:0] off);
      place_jump(b_type(13'd8, rb, ra, f3), taken ? pc_build + 8 : pc_build + 4);
      if (taken) begin
         place_trap_store();
      end else begin
         place(s_type(off, 5'd1, 5'd10, `RV32_F3_SW));
         expect_store(32'h100 + off, 32'd5, 4'b1111);
      end
   endtask

   task automatic build_program();
      logic [31:0] v1;
      logic [31:0] v2;
      logic [31:0] v3;
      logic [31:0] v5;
      logic [31:0] w;
      logic [31:0] link;
      v1 = 32'd5;
      v2 = -32'sd3;
      v3 = 32'h1234_5000;
      v5 = 32'hFFFF_FAAA;
      pc_build = 0;
      for (int i = 0; i < 256; i++) begin
         u_mem.rom[i] = 32'h0000_0013;
      end
      place(i_type(12'd5, 5'd0, `RV32_F3_ADDSUB, 5'd1, `RV32_OP_IMM));
      place(i_type(12'hFFD, 5'd0, `RV32_F3_ADDSUB, 5'd2, `RV32_OP_IMM));
      place(u_type(20'h12345, 5'd3, `RV32_OP_LUI));
      place(i_type(12'h100, 5'd0, `RV32_F3_ADDSUB, 5'd10, `RV32_OP_IMM));
      place(r_type(7'd0, 5'd2, 5'd1, `RV32_F3_ADDSUB, 5'd4));
      store_x4(12'h00, v1 + v2);
      place(r_type(`RV32_F7_ALT, 5'd1, 5'd2, `RV32_F3_ADDSUB, 5'd4));
      store_x4(12'h04, v2 - v1);
      place(r_type(7'd0, 5'd1, 5'd1, `RV32_F3_SLL, 5'd4));
      store_x4(12'h08, v1 << v1[4:0]);
      place(r_type(7'd0, 5'd1, 5'd2, `RV32_F3_SLT, 5'd4));
      store_x4(12'h0C, {31'd0, $signed(v2) < $signed(v1)});
      place(r_type(7'd0, 5'd1, 5'd2, `RV32_F3_SLTU, 5'd4));
      store_x4(12'h10, {31'd0, v2 < v1});
      place(r_type(7'd0, 5'd2, 5'd3, `RV32_F3_XOR, 5'd4));
      store_x4(12'h14, v3 ^ v2);
      place(r_type(7'd0, 5'd1, 5'd2, `RV32_F3_SR, 5'd4));
      store_x4(12'h18, v2 >> v1[4:0]);
      place(r_type(`RV32_F7_ALT, 5'd1, 5'd2, `RV32_F3_SR, 5'd4));
      store_x4(12'h1C, $unsigned($signed(v2) >>> v1[4:0]));
      place(r_type(7'd0, 5'd1, 5'd3, `RV32_F3_OR, 5'd4));
      store_x4(12'h20, v3 | v1);
      place(r_type(7'd0, 5'd2, 5'd3, `RV32_F3_AND, 5'd4));
      store_x4(12'h24, v3 & v2);
      place(i_type(12'hFFE, 5'd2, `RV32_F3_SLT, 5'd4, `RV32_OP_IMM));
      store_x4(12'h28, {31'd0, $signed(v2) < -32'sd2});
      place(i_type(12'h7FF, 5'd1, `RV32_F3_XOR, 5'd4, `RV32_OP_IMM));
      store_x4(12'h2C, v1 ^ 32'h7FF);
      place(i_type({`RV32_F7_ALT, 5'd4}, 5'd3, `RV32_F3_SR, 5'd4, `RV32_OP_IMM));
      store_x4(12'h30, $unsigned($signed(v3) >>> 4));
      place(s_type(12'h34, 5'd3, 5'd10, `RV32_F3_SW));
      expect_store(32'h134, v3, 4'b1111);
      w = pc_build + 32'h1000;
      place(u_type(20'h00001, 5'd4, `RV32_OP_AUIPC));
      store_x4(12'h38, w);
      // sub-word stores at each lane
      place(i_type(12'hAAA, 5'd0, `RV32_F3_ADDSUB, 5'd5, `RV32_OP_IMM));
      for (int k = 0; k < 4; k++) begin
         place(s_type(12'h40 + k, 5'd5, 5'd10, `RV32_F3_SB));
         expect_store(32'h140 + k, {4{v5[7:0]}}, 4'b0001 << k);
      end
      place(s_type(12'h50, 5'd5, 5'd10, `RV32_F3_SH));
      expect_store(32'h150, {2{v5[15:0]}}, 4'b0011);
      place(s_type(12'h52, 5'd5, 5'd10, `RV32_F3_SH));
      expect_store(32'h152, {2{v5[15:0]}}, 4'b1100);
      // loads from untouched fill words at 0x200, copied out with SW
      place(i_type(12'h200, 5'd0, `RV32_F3_ADDSUB, 5'd11, `RV32_OP_IMM));
      w = u_mem.fill_word(32'h80);
      for (int k = 0; k < 4; k++) begin
         place(i_type(k, 5'd11, `RV32_F3_LB, 5'd4, `RV32_OP_LOAD));
         store_x4(12'h80 + 4*k, {{24{w[8*k+7]}}, w[8*k +: 8]});
      end
      place(i_type(12'd1, 5'd11, `RV32_F3_LBU, 5'd4, `RV32_OP_LOAD));
      store_x4(12'h90, {24'd0, w[15:8]});
      place(i_type(12'd3, 5'd11, `RV32_F3_LBU, 5'd4, `RV32_OP_LOAD));
      store_x4(12'h94, {24'd0, w[31:24]});
      place(i_type(12'd0, 5'd11, `RV32_F3_LH, 5'd4, `RV32_OP_LOAD));
      store_x4(12'h98, {{16{w[15]}}, w[15:0]});
      place(i_type(12'd2, 5'd11, `RV32_F3_LH, 5'd4, `RV32_OP_LOAD));
      store_x4(12'h9C, {{16{w[31]}}, w[31:16]});
      place(i_type(12'd2, 5'd11, `RV32_F3_LHU, 5'd4, `RV32_OP_LOAD));
      store_x4(12'hA0, {16'd0, w[31:16]});
      place(i_type(12'd4, 5'd11, `RV32_F3_LW, 5'd4, `RV32_OP_LOAD));
      store_x4(12'hA4, u_mem.fill_word(32'h81));
      // branches, x1 = 5 and x2 = -3
      cond_branch(`RV32_F3_BEQ, 5'd1, 5'd1, 1'b1, 12'h0);
      cond_branch(`RV32_F3_BNE, 5'd1, 5'd1, 1'b0, 12'hB0);
      cond_branch(`RV32_F3_BLT, 5'd2, 5'd1, 1'b1, 12'h0);
      cond_branch(`RV32_F3_BGE, 5'd2, 5'd1, 1'b0, 12'hB4);
      cond_branch(`RV32_F3_BLTU, 5'd1, 5'd2, 1'b1, 12'h0);
      cond_branch(`RV32_F3_BGEU, 5'd1, 5'd2, 1'b0, 12'hB8);
      link = pc_build + 4;
      place_jump(j_type(21'd8, 5'd7), pc_build + 8);
      place_trap_store();
      place(s_type(12'hC0, 5'd7, 5'd10, `RV32_F3_SW));
      expect_store(32'h1C0, link, 4'b1111);
      // jalr offset 13 lands on an odd sum, bit 0 is dropped
      w = pc_build;
      place(u_type(20'd0, 5'd8, `RV32_OP_AUIPC));
      place_jump(i_type(12'd13, 5'd8, 3'b000, 5'd9, `RV32_OP_JALR), w + 12);
      place_trap_store();
      place(s_type(12'hC4, 5'd9, 5'd10, `RV32_F3_SW));
      expect_store(32'h1C4, w + 8, 4'b1111);
      place(32'h0000_000F);
      place_jump(j_type(21'd0, 5'd0), pc_build);
   endtask

   task automatic value_error(input string name, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
      $display("error t=%0t %s expected %h actual %h", $time, name, exp_v, act_v);
      value_errs++;
   endtask

   always @(posedge CLK) begin
      if (random_waits) begin
         I_MEM_WAIT <= (($random(seed) & 3) == 0);
         D_MEM_WAIT <= (($random(seed) & 3) == 0);
      end else begin
         I_MEM_WAIT <= 1'b0;
         D_MEM_WAIT <= 1'b0;
      end
   end

   // fetch, store and reset monitor
   always @(posedge CLK) begin
      cycle <= cycle + 1;
      // synchronous reset reaches the outputs one edge after it is applied
      if (rst_held) begin
         assert (!D_MEM_ENA && D_MEM_WSTB == 4'b0000)
            else value_error("D_MEM_ENA/D_MEM_WSTB", 32'd0, {D_MEM_ENA, D_MEM_WSTB});
      end
      if (rst_held && RST_N) begin
         assert (I_MEM_ENA) else value_error("I_MEM_ENA", 32'd1, I_MEM_ENA);
      end
      rst_held <= !RST_N;
      if (!RST_N) begin
         store_count <= 0;
         first_fetch <= 1'b1;
         halted <= 1'b0;
      end else begin
         if (I_MEM_ENA && !I_MEM_WAIT) begin
            if (first_fetch) begin
               assert (I_MEM_ADDR == 32'd0) else value_error("I_MEM_ADDR", 32'd0, I_MEM_ADDR);
            end else begin
               assert (I_MEM_ADDR == exp_next[prev_fetch[9:2]])
                  else value_error("I_MEM_ADDR", exp_next[prev_fetch[9:2]], I_MEM_ADDR);
               if (!random_waits) begin
                  assert (cycle - last_fetch_cycle == 5)
                     else value_error("fetch spacing", 32'd5, cycle - last_fetch_cycle);
               end
               if (I_MEM_ADDR == prev_fetch) begin
                  halted <= 1'b1;
               end
            end
            first_fetch <= 1'b0;
            prev_fetch <= I_MEM_ADDR;
            last_fetch_cycle <= cycle;
         end
         if (D_MEM_ENA && !D_MEM_WAIT && D_MEM_WSTB != 4'b0000) begin
            if (store_count < exp_addr.size()) begin
               assert (D_MEM_ADDR == exp_addr[store_count])
                  else value_error("D_MEM_ADDR", exp_addr[store_count], D_MEM_ADDR);
               assert (D_MEM_WDATA == exp_data[store_count])
                  else value_error("D_MEM_WDATA", exp_data[store_count], D_MEM_WDATA);
               assert (D_MEM_WSTB == exp_strb[store_count])
                  else value_error("D_MEM_WSTB", exp_strb[store_count], D_MEM_WSTB);
            end else begin
               $display("t=%0t unexpected extra store to address %h", $time, D_MEM_ADDR);
               other_errs++;
            end
            store_count <= store_count + 1;
         end
      end
   end

   task automatic run_program(input logic with_waits);
      int n;
      @(posedge CLK);
      RST_N <= 1'b0;
      random_waits <= with_waits;
      repeat (8) @(posedge CLK);
      RST_N <= 1'b1;
      n = 0;
      while (!halted && n < 20000) begin
         @(posedge CLK);
         n++;
      end
      if (!halted) begin
         $display("timeout: the core never reached its final self loop");
         other_errs++;
      end else begin
         assert (store_count == exp_addr.size())
            else value_error("store_count", exp_addr.size(), store_count);
      end
   endtask

   initial begin
      CLK = 1'b0;
      RST_N = 1'b0;
      I_MEM_WAIT = 1'b0;
      D_MEM_WAIT = 1'b0;
      random_waits = 1'b0;
      value_errs = 0;
      other_errs = 0;
      cycle = 0;
      last_fetch_cycle = 0;
      prev_fetch = '0;
      first_fetch = 1'b1;
      halted = 1'b0;
      rst_held = 1'b0;
      store_count = 0;
      build_program();
      run_program(1'b0);
      run_program(1'b1);
      $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
      if (value_errs == 0 && other_errs == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* files.f */
+incdir+hw
hw/rv32_pkg.sv
hw/rv32_dec_if.sv
hw/rv32_decoder.sv
hw/rv32_regfile.sv
hw/rv32_execute.sv
hw/rv32_lsu.sv
hw/rv32_core.sv
verification/rv32_tb_mem.sv
verification/rv32_tb.sv
